// ==== common/board_pkg.sv ====
// Shared definitions for the board wrapper and the mini SoC
// Pad count, UART byte width and fan setting width
// Command opcodes of the UART GPIO link
// Default divider values for the RTC tick and the UART bit time

package board_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // GPIO pads on the board
  localparam int unsigned GpioCountDef = 4;

  // UART data width
  localparam int unsigned ByteW = 8;

  // Fan duty setting, three switches
  localparam int unsigned FanSettingW = 3;

  ////////////////////////////////////////
  // Dividers
  ////////////////////////////////////////

  // RTC half-period in soc_clk cycles
  localparam int unsigned RtcDivDef = 1526;

  // soc_clk cycles per UART bit
  localparam int unsigned BaudDivDef = 174;

  // Opcode in the two top bits of a command byte
  typedef enum logic [1:0] {
    op_nop     = 2'b00,
    op_set_out = 2'b01,
    op_set_oe  = 2'b10,
    op_query   = 2'b11
  } cmd_op_e;

endpackage

// ==== design/rst_sync.sv ====
// Reset synchronizer
// Asserts at once, releases on the second soc_clk edge after the raw reset

`timescale 1ns/10ps

module rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rst_sync_n_o
);

  // A one travels through both stages after release
  logic [1:0] sync_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n_o = sync_q[1];

endmodule

// ==== design/rtc_divider.sv ====
// Slow real-time clock from soc_clk
// Square wave that toggles every RtcDiv+1 cycles

`timescale 1ns/10ps

module rtc_divider import board_pkg::*; #(
  parameter int unsigned RtcDiv = RtcDivDef
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_clk_o
);

  localparam int unsigned     CntW   = $clog2(RtcDiv + 1);
  localparam logic [CntW-1:0] CntMax = CntW'(RtcDiv);

  logic [CntW-1:0] cnt_q;
  logic            rtc_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_q == CntMax) begin
      // Half period done
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + CntW'(1);
    end
  end

  assign rtc_clk_o = rtc_q;

  // Counter stays inside the half period
  assert property (@(posedge soc_clk) disable iff (!rst_n) cnt_q <= CntMax)
    else $error("rtc_divider: counter %0d above %0d", cnt_q, CntMax);

endmodule

// ==== fan_ctrl/fan_ctrl.sv ====
// Fan PWM generator
// Eight-step period, duty taken from a three-bit setting
// Setting is latched only at the period boundary

`timescale 1ns/10ps

module fan_ctrl import board_pkg::*; (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  logic [FanSettingW-1:0] pwm_setting_i,
  output logic                   fan_pwm_o
);

  ////////////////////////////////////////
  // Period counter
  ////////////////////////////////////////

  logic [FanSettingW-1:0] period_q;
  logic [FanSettingW-1:0] setting_q;
  logic                   period_end;

  // Last step of the period
  assign period_end = (period_q == '1);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      period_q  <= '0;
      setting_q <= '0;
    end else begin
      period_q <= period_q + FanSettingW'(1);
      // New duty only from the next period start
      if (period_end) begin
        setting_q <= pwm_setting_i;
      end
    end
  end

  ////////////////////////////////////////
  // Duty compare
  ////////////////////////////////////////

  // High for the first setting_q steps
  assign fan_pwm_o = (period_q < setting_q);

endmodule

// ==== mini_soc/uart_link.sv ====
// 8N1 UART link
// Receiver with input synchronizer and mid-bit sampling
// Transmitter with a ten-bit frame shift register
// Both directions share the BaudDiv bit time

`timescale 1ns/10ps

module uart_link import board_pkg::*; #(
  parameter int unsigned BaudDiv = BaudDivDef
) (
  input  logic             soc_clk,
  input  logic             rst_n,
  input  logic             uart_rx_i,
  output logic             uart_tx_o,
  output logic             rx_valid_o,
  output logic [ByteW-1:0] rx_data_o,
  input  logic             tx_start_i,
  input  logic [ByteW-1:0] tx_data_i,
  output logic             tx_busy_o
);

  localparam int unsigned     CntW    = $clog2(BaudDiv + 1);
  localparam int unsigned     FrameW  = ByteW + 2;
  localparam int unsigned     BitW    = $clog2(FrameW + 1);
  localparam logic [CntW-1:0] BitLast = CntW'(BaudDiv - 1);
  // Start wait, shortened by the two synchronizer stages
  localparam logic [CntW-1:0] HalfBit = CntW'(BaudDiv / 2 - 1);
  localparam logic [BitW-1:0] StopIdx = BitW'(FrameW - 1);

  ////////////////////////////////////////
  // Receiver
  ////////////////////////////////////////

  logic             rx_meta_q;
  logic             rx_line_q;
  logic             rx_busy_q;
  logic [CntW-1:0]  rx_cnt_q;
  logic [BitW-1:0]  rx_idx_q;
  logic             rx_valid_q;
  logic [ByteW-1:0] rx_shift_q;
  logic             rx_sample;
  logic             rx_take;

  // Mid-bit sample point, index 0 is the start bit
  assign rx_sample = rx_busy_q && (rx_cnt_q == '0);
  assign rx_take   = rx_sample && (rx_idx_q != '0) && (rx_idx_q != StopIdx);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta_q  <= 1'b1;
      rx_line_q  <= 1'b1;
      rx_busy_q  <= 1'b0;
      rx_cnt_q   <= '0;
      rx_idx_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_meta_q  <= uart_rx_i;
      rx_line_q  <= rx_meta_q;
      rx_valid_q <= 1'b0;
      if (!rx_busy_q) begin
        // Falling edge opens a frame
        if (!rx_line_q) begin
          rx_busy_q <= 1'b1;
          rx_cnt_q  <= HalfBit;
          rx_idx_q  <= '0;
        end
      end else if (!rx_sample) begin
        rx_cnt_q <= rx_cnt_q - CntW'(1);
      end else begin
        rx_cnt_q <= BitLast;
        rx_idx_q <= rx_idx_q + BitW'(1);
        if ((rx_idx_q == '0) && rx_line_q) begin
          // Line back high, only a glitch
          rx_busy_q <= 1'b0;
        end else if (rx_idx_q == StopIdx) begin
          // Bad stop bit drops the byte
          rx_busy_q  <= 1'b0;
          rx_valid_q <= rx_line_q;
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge soc_clk) begin
    if (rx_take) begin
      rx_shift_q <= {rx_line_q, rx_shift_q[ByteW-1:1]};
    end
  end

  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = rx_shift_q;

  ////////////////////////////////////////
  // Transmitter
  ////////////////////////////////////////

  logic [FrameW-1:0] tx_frame_q;
  logic [BitW-1:0]   tx_left_q;
  logic [CntW-1:0]   tx_cnt_q;

  assign tx_busy_o = (tx_left_q != '0);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_frame_q <= '1;
      tx_left_q  <= '0;
      tx_cnt_q   <= '0;
    end else if (!tx_busy_o) begin
      // Start, data, stop; a start while busy is not seen here
      if (tx_start_i) begin
        tx_frame_q <= {1'b1, tx_data_i, 1'b0};
        tx_left_q  <= BitW'(FrameW);
        tx_cnt_q   <= BitLast;
      end
    end else if (tx_cnt_q != '0) begin
      tx_cnt_q <= tx_cnt_q - CntW'(1);
    end else begin
      tx_frame_q <= {1'b1, tx_frame_q[FrameW-1:1]};
      tx_left_q  <= tx_left_q - BitW'(1);
      tx_cnt_q   <= BitLast;
    end
  end

  // Idle frame is all ones
  assign uart_tx_o = tx_frame_q[0];

  // Received byte is a single-cycle strobe
  assert property (@(posedge soc_clk) disable iff (!rst_n) rx_valid_o |=> !rx_valid_o)
    else $error("uart_link: rx_valid_o held longer than one cycle");

endmodule

// ==== mini_soc/gpio_regs.sv ====
// GPIO register block behind the UART link
// Command decoder for set-out, set-enable and query
// Output and enable registers, query reply and status flag

`timescale 1ns/10ps

module gpio_regs import board_pkg::*; #(
  parameter int unsigned GpioCount = GpioCountDef
) (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 fetch_en_i,
  input  logic                 rx_valid_i,
  input  logic [ByteW-1:0]     rx_data_i,
  output logic                 tx_start_o,
  output logic [ByteW-1:0]     tx_data_o,
  input  logic                 tx_busy_i,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_oe_o,
  output logic                 status_o
);

  localparam int unsigned Half = ByteW / 2;

  // Enables and inputs must share one reply byte
  if (GpioCount > Half) begin : g_count_check
    $error("gpio_regs: GpioCount %0d does not fit a reply nibble", GpioCount);
  end

  cmd_op_e              op;
  logic                 exec;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] oe_q;
  logic                 status_q;
  logic                 tx_start_q;
  logic [ByteW-1:0]     reply;
  logic [ByteW-1:0]     tx_data_q;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  assign op   = cmd_op_e'(rx_data_i[ByteW-1 -: 2]);
  assign exec = rx_valid_i && fetch_en_i;

  // Enables on top, already masked pad inputs below
  always_comb begin
    reply                    = '0;
    reply[Half +: GpioCount] = oe_q;
    reply[GpioCount-1:0]     = gpio_i;
  end

  ////////////////////////////////////////
  // Registers
  ////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      out_q      <= '0;
      oe_q       <= '0;
      status_q   <= 1'b0;
      tx_start_q <= 1'b0;
    end else begin
      tx_start_q <= 1'b0;
      if (exec) begin
        case (op)
          op_set_out: out_q      <= rx_data_i[GpioCount-1:0];
          op_set_oe:  oe_q       <= rx_data_i[GpioCount-1:0];
          op_query:   tx_start_q <= 1'b1;
          default:    ;
        endcase
        // Sticky once the link has done something
        if (op != op_nop) begin
          status_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge soc_clk) begin
    if (exec && (op == op_query)) begin
      tx_data_q <= reply;
    end
  end

  assign gpio_o     = out_q;
  assign gpio_oe_o  = oe_q;
  assign status_o   = status_q;
  assign tx_start_o = tx_start_q;
  assign tx_data_o  = tx_data_q;

  // Query came in before the previous reply had left the transmitter
  assert property (@(posedge soc_clk) disable iff (!rst_n) tx_start_o |-> !tx_busy_i)
    else $error("gpio_regs: reply 0x%02h dropped, transmitter busy", tx_data_o);

endmodule

// ==== mini_soc/mini_soc.sv ====
// Stand-in SoC
// UART link feeding the GPIO register block

`timescale 1ns/10ps

module mini_soc import board_pkg::*; #(
  parameter int unsigned GpioCount = GpioCountDef,
  parameter int unsigned BaudDiv   = BaudDivDef
) (
  input  logic                 soc_clk,
  input  logic                 rst_n,
  input  logic                 fetch_en_i,
  input  logic                 uart_rx_i,
  output logic                 uart_tx_o,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_oe_o,
  output logic                 status_o
);

  // Byte strobes between link and registers
  logic             rx_valid;
  logic [ByteW-1:0] rx_data;
  logic             tx_start;
  logic [ByteW-1:0] tx_data;
  logic             tx_busy;

  uart_link #(
    .BaudDiv ( BaudDiv )
  ) i_uart_link (
    .soc_clk    ( soc_clk   ),
    .rst_n      ( rst_n     ),
    .uart_rx_i  ( uart_rx_i ),
    .uart_tx_o  ( uart_tx_o ),
    .rx_valid_o ( rx_valid  ),
    .rx_data_o  ( rx_data   ),
    .tx_start_i ( tx_start  ),
    .tx_data_i  ( tx_data   ),
    .tx_busy_o  ( tx_busy   )
  );

  gpio_regs #(
    .GpioCount ( GpioCount )
  ) i_gpio_regs (
    .soc_clk    ( soc_clk    ),
    .rst_n      ( rst_n      ),
    .fetch_en_i ( fetch_en_i ),
    .rx_valid_i ( rx_valid   ),
    .rx_data_i  ( rx_data    ),
    .tx_start_o ( tx_start   ),
    .tx_data_o  ( tx_data    ),
    .tx_busy_i  ( tx_busy    ),
    .gpio_i     ( gpio_i     ),
    .gpio_o     ( gpio_o     ),
    .gpio_oe_o  ( gpio_oe_o  ),
    .status_o   ( status_o   )
  );

endmodule

// ==== design/board_top.sv ====
// Board top level of the SoC prototype
// Reset source selection and reset synchronizer
// RTC divider, fan PWM and the stand-in SoC
// Per-pad masking by output enable

`timescale 1ns/10ps

module board_top import board_pkg::*; #(
  parameter int unsigned GpioCount = GpioCountDef,
  parameter int unsigned RtcDiv    = RtcDivDef,
  parameter int unsigned BaudDiv   = BaudDivDef
) (
  input  logic                   soc_clk,
  input  logic                   rst_n,
  input  logic                   sw_reset_i,
  input  logic                   fetch_en_i,
  input  logic [GpioCount-1:0]   gpio_i,
  output logic [GpioCount-1:0]   gpio_o,
  input  logic [FanSettingW-1:0] fan_sw_i,
  output logic                   fan_pwm_o,
  output logic                   rtc_clk_o,
  output logic                   status_o,
  input  logic                   uart_rx_i,
  output logic                   uart_tx_o
);

  ////////////////////////////////////////
  // Reset
  ////////////////////////////////////////

  logic raw_rst_n;
  logic sys_rst_n;

  // Board button or software switch
  assign raw_rst_n = rst_n & ~sw_reset_i;

  rst_sync i_rst_sync (
    .soc_clk      ( soc_clk   ),
    .rst_n        ( raw_rst_n ),
    .rst_sync_n_o ( sys_rst_n )
  );

  ////////////////////////////////////////
  // Pads
  ////////////////////////////////////////

  logic [GpioCount-1:0] soc_gpio_in;
  logic [GpioCount-1:0] soc_gpio_out;
  logic [GpioCount-1:0] soc_gpio_oe;

  // Driven pads show the output, the others feed the SoC
  for (genvar idx = 0; idx < GpioCount; idx++) begin : g_pad
    assign gpio_o[idx]      = soc_gpio_oe[idx] ? soc_gpio_out[idx] : 1'b0;
    assign soc_gpio_in[idx] = soc_gpio_oe[idx] ? 1'b0 : gpio_i[idx];
  end

  ////////////////////////////////////////
  // Peripherals
  ////////////////////////////////////////

  rtc_divider #(
    .RtcDiv ( RtcDiv )
  ) i_rtc_divider (
    .soc_clk   ( soc_clk   ),
    .rst_n     ( sys_rst_n ),
    .rtc_clk_o ( rtc_clk_o )
  );

  fan_ctrl i_fan_ctrl (
    .soc_clk       ( soc_clk   ),
    .rst_n         ( sys_rst_n ),
    .pwm_setting_i ( fan_sw_i  ),
    .fan_pwm_o     ( fan_pwm_o )
  );

  mini_soc #(
    .GpioCount ( GpioCount ),
    .BaudDiv   ( BaudDiv   )
  ) i_mini_soc (
    .soc_clk    ( soc_clk      ),
    .rst_n      ( sys_rst_n    ),
    .fetch_en_i ( fetch_en_i   ),
    .uart_rx_i  ( uart_rx_i    ),
    .uart_tx_o  ( uart_tx_o    ),
    .gpio_i     ( soc_gpio_in  ),
    .gpio_o     ( soc_gpio_out ),
    .gpio_oe_o  ( soc_gpio_oe  ),
    .status_o   ( status_o     )
  );

endmodule

// ==== tests/tb_board_top.sv ====
// Testbench for the board top level
// Command table applied in a loop over a UART driver and reply monitor
// Fan PWM duty and RTC period checks, LFSR pad stimulus, watchdog

`timescale 1ns/10ps

module tb_board_top import board_pkg::*; ();

  localparam int unsigned GpioCount   = GpioCountDef;
  localparam int unsigned RtcDiv      = 6;
  localparam int unsigned BaudDiv     = 8;
  localparam int unsigned ClkHalf     = 20;
  localparam int unsigned FrameCycles = 10 * BaudDiv;
  localparam int unsigned TestCycles  = 3 * FrameCycles + 64;
  localparam int          NumSteps    = 12;
  localparam int unsigned WatchdogNs  = (NumSteps * TestCycles + 100) * 2 * ClkHalf;
  localparam logic [16:0] LfsrSeed    = 17'd97216;

  logic                   soc_clk;
  logic                   rst_n;
  logic                   sw_reset;
  logic                   fetch_en;
  logic [GpioCount-1:0]   gpio_in;
  logic [GpioCount-1:0]   gpio_out;
  logic [FanSettingW-1:0] fan_sw;
  logic                   fan_pwm;
  logic                   rtc_clk;
  logic                   status;
  logic                   uart_rx;
  logic                   uart_tx;

  logic [16:0] lfsr_q;
  int unsigned checks;
  int unsigned errors;

  typedef struct packed {
    logic                   sw_rst;
    logic [ByteW-1:0]       cmd;
    logic [FanSettingW-1:0] fan;
    logic                   fetch;
    logic [GpioCount-1:0]   exp_gpio;
    logic                   exp_status;
    logic                   reply;
    logic [GpioCount-1:0]   exp_oe;
  } step_t;

  // sw_rst, cmd, fan, fetch, gpio_o, status, reply expected, enables
  step_t steps [NumSteps] = '{
    '{1'b0, 8'h00, 3'd0, 1'b1, 4'h0, 1'b0, 1'b0, 4'h0},
    '{1'b0, 8'h4A, 3'd3, 1'b1, 4'h0, 1'b1, 1'b0, 4'h0},
    '{1'b0, 8'h8C, 3'd5, 1'b1, 4'h8, 1'b1, 1'b0, 4'hC},
    '{1'b0, 8'hC0, 3'd7, 1'b1, 4'h8, 1'b1, 1'b1, 4'hC},
    '{1'b0, 8'h4F, 3'd1, 1'b0, 4'h8, 1'b1, 1'b0, 4'hC},
    '{1'b0, 8'hC0, 3'd2, 1'b0, 4'h8, 1'b1, 1'b0, 4'hC},
    '{1'b0, 8'h83, 3'd4, 1'b1, 4'h2, 1'b1, 1'b0, 4'h3},
    '{1'b0, 8'hC5, 3'd6, 1'b1, 4'h2, 1'b1, 1'b1, 4'h3},
    '{1'b1, 8'hC0, 3'd0, 1'b1, 4'h0, 1'b1, 1'b1, 4'h0},
    '{1'b0, 8'h8F, 3'd7, 1'b1, 4'h0, 1'b1, 1'b0, 4'hF},
    '{1'b0, 8'h45, 3'd3, 1'b1, 4'h5, 1'b1, 1'b0, 4'hF},
    '{1'b0, 8'hFF, 3'd5, 1'b1, 4'h5, 1'b1, 1'b1, 4'hF}
  };

  board_top #(
    .GpioCount ( GpioCount ),
    .RtcDiv    ( RtcDiv    ),
    .BaudDiv   ( BaudDiv   )
  ) u_dut (
    .soc_clk    ( soc_clk  ),
    .rst_n      ( rst_n    ),
    .sw_reset_i ( sw_reset ),
    .fetch_en_i ( fetch_en ),
    .gpio_i     ( gpio_in  ),
    .gpio_o     ( gpio_out ),
    .fan_sw_i   ( fan_sw   ),
    .fan_pwm_o  ( fan_pwm  ),
    .rtc_clk_o  ( rtc_clk  ),
    .status_o   ( status   ),
    .uart_rx_i  ( uart_rx  ),
    .uart_tx_o  ( uart_tx  )
  );

  initial begin
    soc_clk = 1'b0;
    forever #(ClkHalf) soc_clk = ~soc_clk;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic draw_pads(output logic [GpioCount-1:0] v);
    for (int b = 0; b < GpioCount; b++) begin
      v[b]   = lfsr_q[16];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic expect_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("** Error: %s is 0x%02h, expected 0x%02h", name, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      errors++;
    end
  endtask

  // Start, data LSB first, then stop while waiting for the link strobe
  task automatic send_frame(input logic [ByteW-1:0] data, output logic seen);
    logic [ByteW:0] frame;
    int unsigned    n;
    frame = {data, 1'b0};
    seen  = 1'b0;
    n     = 0;
    for (int b = 0; b < ByteW + 1; b++) begin
      @(negedge soc_clk);
      uart_rx = frame[b];
      repeat (BaudDiv - 1) @(negedge soc_clk);
    end
    @(negedge soc_clk);
    uart_rx = 1'b1;
    while (!seen && n < 2 * BaudDiv) begin
      @(negedge soc_clk);
      seen = u_dut.i_mini_soc.rx_valid;
      n++;
    end
  endtask

  // One reply frame from uart_tx, sampled mid-bit
  task automatic receive_frame(output logic [ByteW-1:0] data, output logic seen,
                               output logic stop);
    int unsigned n;
    data = '0;
    seen = 1'b0;
    stop = 1'b0;
    n    = 0;
    while (!seen && n < 4 * BaudDiv) begin
      @(negedge soc_clk);
      seen = !uart_tx;
      n++;
    end
    if (seen) begin
      repeat (BaudDiv / 2) @(negedge soc_clk);
      for (int b = 0; b < ByteW; b++) begin
        repeat (BaudDiv) @(negedge soc_clk);
        data[b] = uart_tx;
      end
      repeat (BaudDiv) @(negedge soc_clk);
      stop = uart_tx;
    end
  endtask

  task automatic count_fan(output int unsigned high);
    high = 0;
    repeat (8) begin
      @(negedge soc_clk);
      if (fan_pwm) high++;
    end
  endtask

  // Cycles from one rtc_clk change to the next
  task automatic measure_rtc(output int unsigned period);
    logic        last;
    int unsigned n;
    period = 0;
    n      = 0;
    @(negedge soc_clk);
    last = rtc_clk;
    while (rtc_clk == last && n < 4 * RtcDiv + 4) begin
      @(negedge soc_clk);
      n++;
    end
    last = rtc_clk;
    while (rtc_clk == last && period < 4 * RtcDiv + 4) begin
      @(negedge soc_clk);
      period++;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    logic [GpioCount-1:0] pads;
    logic                 seen;
    logic                 stop;
    logic [ByteW-1:0]     reply;
    int unsigned          fan_high;
    int unsigned          rtc_period;
    int unsigned          errors_before;
    rst_n    = 1'b0;
    sw_reset = 1'b0;
    fetch_en = 1'b0;
    gpio_in  = '0;
    fan_sw   = '0;
    uart_rx  = 1'b1;
    lfsr_q   = LfsrSeed;
    checks   = 0;
    errors   = 0;
    repeat (10) @(negedge soc_clk);
    rst_n = 1'b1;
    repeat (3) @(negedge soc_clk);

    expect_value("uart_tx_o", 8'(uart_tx), 8'h01);
    expect_value("gpio_o", 8'(gpio_out), 8'h00);
    expect_value("status_o", 8'(status), 8'h00);
    expect_value("fan_pwm_o", 8'(fan_pwm), 8'h00);
    expect_value("rtc_clk_o", 8'(rtc_clk), 8'h00);
    $display("reset values: %s", (errors == 0) ? "ok" : "mismatch");

    for (int i = 0; i < NumSteps; i++) begin
      errors_before = errors;
      if (steps[i].sw_rst) begin
        @(negedge soc_clk);
        sw_reset = 1'b1;
        repeat (2) @(negedge soc_clk);
        sw_reset = 1'b0;
        repeat (3) @(negedge soc_clk);
        expect_value("gpio_o", 8'(gpio_out), 8'h00);
        expect_value("status_o", 8'(status), 8'h00);
      end
      @(negedge soc_clk);
      draw_pads(pads);
      gpio_in  = pads;
      fan_sw   = steps[i].fan;
      fetch_en = steps[i].fetch;

      send_frame(steps[i].cmd, seen);
      expect_true(seen, $sformatf("Command 0x%02h never reached the link", steps[i].cmd));
      // Write lands on the edge after the strobe
      @(negedge soc_clk);
      expect_value("gpio_o", 8'(gpio_out), 8'(steps[i].exp_gpio));
      expect_value("status_o", 8'(status), 8'(steps[i].exp_status));

      receive_frame(reply, seen, stop);
      if (steps[i].reply) begin
        expect_true(seen, "No reply frame on uart_tx_o after a query");
        expect_true(stop, "Reply frame ended with a low stop bit");
        expect_value("uart_tx_o reply", reply, {steps[i].exp_oe, pads & ~steps[i].exp_oe});
      end else begin
        expect_true(!seen, "Reply frame on uart_tx_o where none was due");
      end

      count_fan(fan_high);
      expect_value("fan_pwm_o high count", 8'(fan_high), 8'(steps[i].fan));
      measure_rtc(rtc_period);
      expect_value("rtc_clk_o period", 8'(rtc_period), 8'(RtcDiv + 1));

      $display("step %0d cmd 0x%02h fan %0d fetch %0d: %s", i, steps[i].cmd, steps[i].fan,
               steps[i].fetch, (errors == errors_before) ? "ok" : "mismatch");
    end

    $display("%0d steps, %0d checks, %0d errors", NumSteps, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Upper bound on the whole table run
  initial begin
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the run did not complete", WatchdogNs);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== board_top.f ====
common/board_pkg.sv
design/rst_sync.sv
design/rtc_divider.sv
fan_ctrl/fan_ctrl.sv
mini_soc/uart_link.sv
mini_soc/gpio_regs.sv
mini_soc/mini_soc.sv
design/board_top.sv
tests/tb_board_top.sv

// ==== Makefile ====
# Verilator build and run of the board top level testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= board_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf $(BUILD_DIR)
